// File: hw/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// ------------------------------------------------------------
// Fetch front end sizing
// ------------------------------------------------------------

// Address and data width of the core
`define FETCH_XLEN 64

// Instruction length in bits, sequential step is ILEN/8 bytes
`define FETCH_ILEN 32

// BTB depth, power of two for the round-robin pointer
`define FETCH_BTB_ENTRIES 8

// First fetch address after reset
`define FETCH_BOOT_PC 64'h0000_0000_8000_0000

`endif

// File: hw/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

  // ------------------------------------------------------------
  // Branch unit resolution
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] target;
    logic                   taken;
    logic                   mispredict;
  } resolution_t;

  // BTB lookup result for the current fetch PC
  typedef struct packed {
    logic                   hit;
    logic                   taken;
    logic [`FETCH_XLEN-1:0] target;
  } prediction_t;

  // Stored contents of one BTB entry
  // Tag is the pc without its two low bits
  typedef struct packed {
    logic                   valid;
    logic [`FETCH_XLEN-3:0] tag;
    logic [`FETCH_XLEN-1:0] target;
    logic [1:0]             cnt;
  } btb_line_t;

endpackage

// File: hw/btb_entry.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module btb_entry import fetch_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`FETCH_XLEN-1:0] fetch_pc_i,
  input  logic [`FETCH_XLEN-1:0] upd_pc_i,
  input  logic [`FETCH_XLEN-1:0] upd_target_i,
  input  logic                   upd_taken_i,
  input  logic                   write_i,
  input  logic                   alloc_i,
  output btb_line_t              line_o,
  output logic                   lookup_hit_o,
  output logic                   update_hit_o
);

  localparam int unsigned TAG_W = `FETCH_XLEN - 2;

  logic                   valid_q;
  logic [1:0]             cnt_q;
  logic [1:0]             cnt_d;
  logic [TAG_W-1:0]       tag_q;
  logic [`FETCH_XLEN-1:0] target_q;

  // ------------------------------------------------------------
  // 2-bit saturating counter
  // ------------------------------------------------------------
  always_comb begin
    cnt_d = cnt_q;
    if (alloc_i) begin
      // Fresh entry starts weakly taken
      cnt_d = 2'b10;
    end else if (write_i) begin
      if (upd_taken_i && (cnt_q != 2'b11)) begin
        cnt_d = cnt_q + 2'd1;
      end else if (!upd_taken_i && (cnt_q != 2'b00)) begin
        cnt_d = cnt_q - 2'd1;
      end
    end
  end

  // Valid bit and counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      cnt_q   <= 2'b00;
    end else begin
      if (alloc_i) begin
        valid_q <= 1'b1;
      end
      cnt_q <= cnt_d;
    end
  end

  // Tag and target storage
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      tag_q <= upd_pc_i[`FETCH_XLEN-1:2];
    end
    // Target refreshed on every taken outcome
    if (alloc_i || (write_i && upd_taken_i)) begin
      target_q <= upd_target_i;
    end
  end

  // Tag compares, fetch side and resolution side
  assign lookup_hit_o = valid_q && (tag_q == fetch_pc_i[`FETCH_XLEN-1:2]);
  assign update_hit_o = valid_q && (tag_q == upd_pc_i[`FETCH_XLEN-1:2]);

  assign line_o = '{valid: valid_q, tag: tag_q, target: target_q, cnt: cnt_q};

endmodule

// File: hw/btb_alloc.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module btb_alloc #(
  parameter int unsigned NUM_ENTRIES = `FETCH_BTB_ENTRIES
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   res_valid_i,
  input  logic                   res_taken_i,
  input  logic [NUM_ENTRIES-1:0] update_hit_i,
  output logic [NUM_ENTRIES-1:0] write_o,
  output logic [NUM_ENTRIES-1:0] alloc_o
);

  localparam int unsigned PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

  logic [PTR_W-1:0]       ptr_q;
  logic [NUM_ENTRIES-1:0] first_hit;
  logic                   new_branch;

  // Lowest matching entry only, same order as the lookup side
  assign first_hit = update_hit_i & (~update_hit_i + 1'b1);

  // Taken branch not yet tracked by any entry
  assign new_branch = res_valid_i && res_taken_i && !(|update_hit_i);

  // ------------------------------------------------------------
  // Per-entry strobes
  // ------------------------------------------------------------
  always_comb begin
    write_o = '0;
    alloc_o = '0;
    if (res_valid_i) begin
      write_o = first_hit;
    end
    if (new_branch) begin
      alloc_o[ptr_q] = 1'b1;
    end
  end

  // Round-robin victim pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (new_branch) begin
      if (ptr_q == PTR_W'(NUM_ENTRIES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

endmodule

// File: hw/btb_lookup.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module btb_lookup import fetch_pkg::*; #(
  parameter int unsigned NUM_ENTRIES = `FETCH_BTB_ENTRIES
) (
  input  btb_line_t              lines_i [NUM_ENTRIES],
  input  logic [NUM_ENTRIES-1:0] lookup_hit_i,
  output prediction_t            pred_o
);

  btb_line_t sel_line;

  // ------------------------------------------------------------
  // Priority select, lowest index wins
  // ------------------------------------------------------------
  always_comb begin
    sel_line = lines_i[0];
    // Walk downwards so the lowest hitting index is written last
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (lookup_hit_i[i]) begin
        sel_line = lines_i[i];
      end
    end
  end

  // Prediction fields
  always_comb begin
    pred_o.hit    = |lookup_hit_i;
    // Counter MSB set means taken
    pred_o.taken  = pred_o.hit && sel_line.cnt[1];
    pred_o.target = sel_line.target;
  end

endmodule

// File: hw/pc_gen.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module pc_gen import fetch_pkg::*; #(
  parameter logic [`FETCH_XLEN-1:0] BOOT_PC = `FETCH_BOOT_PC
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   comm_except_raised_i,
  input  logic [`FETCH_XLEN-1:0] comm_except_pc_i,
  input  logic                   bu_res_valid_i,
  input  resolution_t            bu_res_i,
  input  prediction_t            pred_i,
  input  logic                   early_jump_valid_i,
  input  logic [`FETCH_XLEN-1:0] early_jump_target_i,
  input  logic [`FETCH_XLEN-1:0] early_jump_old_pc_i,
  input  logic                   mem_ready_i,
  output logic [`FETCH_XLEN-1:0] pc_o,
  output logic                   valid_o,
  output logic                   bu_ready_o,
  output logic [`FETCH_XLEN-1:0] next_pc_o
);

  // Sequential step in bytes
  localparam logic [`FETCH_XLEN-1:0] SEQ_STEP = `FETCH_XLEN'(`FETCH_ILEN / 8);

  logic                   mispredict;
  logic                   early_jump;
  logic [`FETCH_XLEN-1:0] add_base;
  logic [`FETCH_XLEN-1:0] add_offset;
  logic [`FETCH_XLEN-1:0] adder_out;

  assign mispredict = bu_res_valid_i && bu_res_i.mispredict;
  // Early jump only counts when no misprediction overrides it
  assign early_jump = early_jump_valid_i && !mispredict;

  // ------------------------------------------------------------
  // Shared adder
  // ------------------------------------------------------------
  always_comb begin
    if (mispredict) begin
      // Not-taken recovery restarts after the branch
      add_base   = bu_res_i.pc;
      add_offset = SEQ_STEP;
    end else if (early_jump) begin
      add_base   = early_jump_old_pc_i;
      add_offset = early_jump_target_i;
    end else begin
      add_base   = pc_o;
      add_offset = SEQ_STEP;
    end
  end

  assign adder_out = add_base + add_offset;

  // ------------------------------------------------------------
  // Next PC priority chain
  // ------------------------------------------------------------
  always_comb begin
    if (comm_except_raised_i) begin
      next_pc_o = comm_except_pc_i;
    end else if (mispredict) begin
      next_pc_o = bu_res_i.taken ? bu_res_i.target : adder_out;
    end else if (pred_i.taken) begin
      next_pc_o = pred_i.target;
    end else begin
      // Early jump or plain sequential step
      next_pc_o = adder_out;
    end
  end

  // PC register, stalls unless memory is ready or decode redirects
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_o <= BOOT_PC;
    end else if (mem_ready_i || early_jump_valid_i) begin
      pc_o <= next_pc_o;
    end
  end

  // Current fetch is squashed on a flush
  assign valid_o    = !comm_except_raised_i && !mispredict;
  assign bu_ready_o = mem_ready_i;

endmodule

// File: hw/fetch_front.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module fetch_front import fetch_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   comm_except_raised_i,
  input  logic [`FETCH_XLEN-1:0] comm_except_pc_i,
  input  logic                   bu_res_valid_i,
  input  resolution_t            bu_res_i,
  input  logic                   early_jump_valid_i,
  input  logic [`FETCH_XLEN-1:0] early_jump_target_i,
  input  logic [`FETCH_XLEN-1:0] early_jump_old_pc_i,
  input  logic                   mem_ready_i,
  output logic [`FETCH_XLEN-1:0] pc_o,
  output logic                   valid_o,
  output logic                   bu_ready_o,
  output logic [`FETCH_XLEN-1:0] next_pc_o
);

  localparam int unsigned N = `FETCH_BTB_ENTRIES;

  prediction_t    pred;
  btb_line_t      lines [N];
  logic [N-1:0]   lookup_hit;
  logic [N-1:0]   update_hit;
  logic [N-1:0]   write;
  logic [N-1:0]   alloc;

  // ------------------------------------------------------------
  // Next PC generation
  // ------------------------------------------------------------
  pc_gen i_pc_gen (
    .clk_i, .rst_ni, .comm_except_raised_i, .comm_except_pc_i,
    .bu_res_valid_i, .bu_res_i, .pred_i(pred), .early_jump_valid_i,
    .early_jump_target_i, .early_jump_old_pc_i, .mem_ready_i,
    .pc_o, .valid_o, .bu_ready_o, .next_pc_o
  );

  // ------------------------------------------------------------
  // Branch target buffer
  // ------------------------------------------------------------
  btb_alloc #(.NUM_ENTRIES(N)) i_btb_alloc (
    .clk_i, .rst_ni, .res_valid_i(bu_res_valid_i), .res_taken_i(bu_res_i.taken),
    .update_hit_i(update_hit), .write_o(write), .alloc_o(alloc)
  );

  // Entries compare against fetch PC and resolution PC
  for (genvar i = 0; i < N; i++) begin : g_entry
    btb_entry i_btb_entry (
      .clk_i, .rst_ni, .fetch_pc_i(pc_o), .upd_pc_i(bu_res_i.pc),
      .upd_target_i(bu_res_i.target), .upd_taken_i(bu_res_i.taken),
      .write_i(write[i]), .alloc_i(alloc[i]), .line_o(lines[i]),
      .lookup_hit_o(lookup_hit[i]), .update_hit_o(update_hit[i])
    );
  end

  btb_lookup #(.NUM_ENTRIES(N)) i_btb_lookup (
    .lines_i(lines), .lookup_hit_i(lookup_hit), .pred_o(pred)
  );

endmodule

// File: bench/tb_fetch_front.sv
`timescale 1ns/1ns
`include "fetch_settings.svh"

module tb_fetch_front import fetch_pkg::*; ();

  localparam int unsigned CLK_PERIOD    = 20;
  localparam int unsigned MAX_STEPS     = 40;
  localparam int unsigned RESET_TIMEOUT = 10;
  localparam logic [`FETCH_XLEN-1:0] BOOT = `FETCH_BOOT_PC;
  // Sequential fetch step in bytes
  localparam logic [`FETCH_XLEN-1:0] STEP = `FETCH_XLEN'(`FETCH_ILEN / 8);

  // All DUT inputs of one step besides clock and reset
  typedef struct packed {
    logic                   exc;
    logic [`FETCH_XLEN-1:0] exc_pc;
    logic                   res_valid;
    resolution_t            res;
    logic                   ej_valid;
    logic [`FETCH_XLEN-1:0] ej_offset;
    logic [`FETCH_XLEN-1:0] ej_old_pc;
    logic                   mem_ready;
  } stim_t;

  logic                   clk;
  logic                   rst_n;
  stim_t                  cur;
  logic [`FETCH_XLEN-1:0] fetch_pc;
  logic                   fetch_valid;
  logic                   bu_ready;
  logic [`FETCH_XLEN-1:0] next_pc;

  // Step table with next PC and valid expected before the edge
  // Expected PC is the one after the edge
  string                  name_tab     [MAX_STEPS];
  stim_t                  stim_tab     [MAX_STEPS];
  logic [`FETCH_XLEN-1:0] exp_next_tab [MAX_STEPS];
  logic                   exp_valid_tab[MAX_STEPS];
  logic [`FETCH_XLEN-1:0] exp_pc_tab   [MAX_STEPS];
  int unsigned            n_steps = 0;

  fetch_front i_dut (
    .clk_i               (clk),            .rst_ni             (rst_n),
    .comm_except_raised_i(cur.exc),        .comm_except_pc_i   (cur.exc_pc),
    .bu_res_valid_i      (cur.res_valid),  .bu_res_i           (cur.res),
    .early_jump_valid_i  (cur.ej_valid),   .early_jump_target_i(cur.ej_offset),
    .early_jump_old_pc_i (cur.ej_old_pc),  .mem_ready_i        (cur.mem_ready),
    .pc_o                (fetch_pc),       .valid_o            (fetch_valid),
    .bu_ready_o          (bu_ready),       .next_pc_o          (next_pc)
  );

  // ------------------------------------------------------------
  // Clock and reset
  // ------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic compare_pc(input string what, input logic [`FETCH_XLEN-1:0] exp_v,
                            input logic [`FETCH_XLEN-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH %s: expected %h, actual %h", what, exp_v, act_v);
      $display("Test FAILED");
      $fatal(1, "address compare failed");
    end
  endtask

  task automatic check_flag(input string what, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH %s: expected %b, actual %b", what, exp_v, act_v);
      $display("Test FAILED");
      $fatal(1, "flag compare failed");
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus builders
  // ------------------------------------------------------------
  // Nothing but the memory ready level
  function automatic stim_t quiet_stim(input logic mem);
    stim_t s;
    s           = '0;
    s.mem_ready = mem;
    return s;
  endfunction

  // Decode redirect adding an offset to the old pc
  function automatic stim_t jump_stim(input logic [`FETCH_XLEN-1:0] old_pc,
                                      input logic [`FETCH_XLEN-1:0] offset, input logic mem);
    stim_t s;
    s           = quiet_stim(mem);
    s.ej_valid  = 1'b1;
    s.ej_offset = offset;
    s.ej_old_pc = old_pc;
    return s;
  endfunction

  // Branch unit resolution with memory ready
  function automatic stim_t resolve_stim(input logic [`FETCH_XLEN-1:0] pc,
                                         input logic [`FETCH_XLEN-1:0] target,
                                         input logic taken, input logic mis);
    stim_t s;
    s                = quiet_stim(1'b1);
    s.res_valid      = 1'b1;
    s.res.pc         = pc;
    s.res.target     = target;
    s.res.taken      = taken;
    s.res.mispredict = mis;
    return s;
  endfunction

  task automatic add_step(input string name, input stim_t s, input logic [`FETCH_XLEN-1:0] nxt,
                          input logic vld, input logic [`FETCH_XLEN-1:0] pc_after);
    name_tab[n_steps]      = name;
    stim_tab[n_steps]      = s;
    exp_next_tab[n_steps]  = nxt;
    exp_valid_tab[n_steps] = vld;
    exp_pc_tab[n_steps]    = pc_after;
    n_steps++;
  endtask

  task automatic build_table();
    stim_t s;
    // Boot address then sequential steps and a memory stall
    add_step("boot_hold", quiet_stim(1'b0), BOOT + STEP, 1'b1, BOOT);
    add_step("seq_0", quiet_stim(1'b1), BOOT + STEP, 1'b1, BOOT + STEP);
    add_step("seq_1", quiet_stim(1'b1), BOOT + 2 * STEP, 1'b1, BOOT + 2 * STEP);
    add_step("stall", quiet_stim(1'b0), BOOT + 3 * STEP, 1'b1, BOOT + 2 * STEP);
    // Resolution fields without the valid strobe
    s           = resolve_stim(64'h6000, 64'h7000, 1'b1, 1'b1);
    s.res_valid = 1'b0;
    add_step("stale_resolution", s, BOOT + 3 * STEP, 1'b1, BOOT + 3 * STEP);
    // Exception alone squashes the fetch
    s        = quiet_stim(1'b1);
    s.exc    = 1'b1;
    s.exc_pc = 64'h1800;
    add_step("exc_only", s, 64'h1800, 1'b0, 64'h1800);
    // Exception beats misprediction and early jump
    s           = resolve_stim(64'h6000, 64'h7000, 1'b0, 1'b1);
    s.exc       = 1'b1;
    s.exc_pc    = 64'h1000;
    s.ej_valid  = 1'b1;
    s.ej_offset = 64'h40;
    s.ej_old_pc = 64'h5000;
    add_step("exc_wins", s, 64'h1000, 1'b0, 64'h1000);
    // Taken miss also allocates X = 0x2000 in entry 0
    add_step("mis_taken", resolve_stim(64'h2000, 64'h3000, 1'b1, 1'b1), 64'h3000, 1'b0, 64'h3000);
    add_step("mis_not_taken", resolve_stim(64'h4000, 64'h4800, 1'b0, 1'b1),
             64'h4000 + STEP, 1'b0, 64'h4000 + STEP);
    // Decode redirect loads even with memory stalled
    add_step("early_jump", jump_stim(64'h5000, 64'h100, 1'b0), 64'h5100, 1'b1, 64'h5100);
    // BTB learning on X
    add_step("goto_x", jump_stim(64'h1F00, 64'h100, 1'b0), 64'h2000, 1'b1, 64'h2000);
    add_step("x_predicts", quiet_stim(1'b1), 64'h3000, 1'b1, 64'h3000);
    add_step("x_not_taken_0", resolve_stim(64'h2000, 64'h3000, 1'b0, 1'b0),
             64'h3000 + STEP, 1'b1, 64'h3000 + STEP);
    add_step("x_not_taken_1", resolve_stim(64'h2000, 64'h3000, 1'b0, 1'b0),
             64'h3000 + 2 * STEP, 1'b1, 64'h3000 + 2 * STEP);
    add_step("goto_x_again", jump_stim(64'h1F00, 64'h100, 1'b0), 64'h2000, 1'b1, 64'h2000);
    // Counter at 0 gives a plain step
    add_step("x_cold", quiet_stim(1'b1), 64'h2000 + STEP, 1'b1, 64'h2000 + STEP);
    // New taken branches b0 upwards fill every entry
    for (int k = 0; k < `FETCH_BTB_ENTRIES; k++) begin
      add_step($sformatf("alloc_%0d", k),
               resolve_stim(64'h9000 + 64'(16 * k), 64'hA000 + 64'(256 * k), 1'b1, 1'b0),
               64'h2004 + STEP * 64'(k + 1), 1'b1, 64'h2004 + STEP * 64'(k + 1));
    end
    add_step("goto_b0", jump_stim(64'h8F00, 64'h100, 1'b1), 64'h9000, 1'b1, 64'h9000);
    add_step("b0_predicts", quiet_stim(1'b1), 64'hA000, 1'b1, 64'hA000);
    // One branch more wraps the pointer onto b0
    add_step("alloc_last",
             resolve_stim(64'h9000 + 64'(16 * `FETCH_BTB_ENTRIES), 64'hB000, 1'b1, 1'b0),
             64'hA000 + STEP, 1'b1, 64'hA000 + STEP);
    add_step("goto_b0_again", jump_stim(64'h8F00, 64'h100, 1'b1), 64'h9000, 1'b1, 64'h9000);
    add_step("b0_evicted", quiet_stim(1'b1), 64'h9000 + STEP, 1'b1, 64'h9000 + STEP);
  endtask

  // ------------------------------------------------------------
  // Step loop
  // ------------------------------------------------------------
  initial begin
    int unsigned wait_cnt;
    cur = quiet_stim(1'b0);
    build_table();
    wait_cnt = 0;
    while (rst_n !== 1'b1) begin
      if (wait_cnt == RESET_TIMEOUT) begin
        $display("Timeout: reset was not released");
        $display("Test FAILED");
        $fatal(1, "reset wait timed out");
      end
      wait_cnt++;
      @(posedge clk);
    end
    for (int i = 0; i < n_steps; i++) begin
      @(negedge clk);
      cur = stim_tab[i];
      // Combinational outputs settle well before the rising edge
      #(CLK_PERIOD / 4);
      compare_pc({name_tab[i], " next_pc_o"}, exp_next_tab[i], next_pc);
      check_flag({name_tab[i], " valid_o"}, exp_valid_tab[i], fetch_valid);
      check_flag({name_tab[i], " bu_ready_o"}, stim_tab[i].mem_ready, bu_ready);
      @(posedge clk);
      #1;
      compare_pc({name_tab[i], " pc_o"}, exp_pc_tab[i], fetch_pc);
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: build.f
+incdir+hw
hw/fetch_pkg.sv
hw/btb_entry.sv
hw/btb_alloc.sv
hw/btb_lookup.sv
hw/pc_gen.sv
hw/fetch_front.sv
bench/tb_fetch_front.sv

// File: run.sh
#!/bin/sh
# Build and run tb_fetch_front with Verilator, verdict comes from sim.log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_fetch_front \
  -o sim_fetch_front > sim.log 2>&1 &&
  ./obj_dir/sim_fetch_front >> sim.log 2>&1 ||
  echo "Test FAILED" >> sim.log
cat sim.log
! grep -q "Test FAILED" sim.log
